//--- build.f
design/icache_pkg.sv
design/icache_array.sv
design/icache_refill.sv
design/icache.sv
design/ifetch.sv
design/fetch_top.sv
sim/axi_rom_model.sv
sim/tb_fetch_top.sv

//--- sim/fetch_vectors.txt
// first word is the number of lines that follow
// columns: redirect target, instructions to collect, stall mask (bit n stalls cycle n mod 16)
// the first line runs from reset and names the reset pc as its target
00000009
// cold start across three lines
00001000 00000014 0000
// revisit, all hits
00001000 00000010 0000
// same index as 0x1000, different tag
00001200 00000008 0000
// back to the evicted line
00001000 00000008 0000
// miss on the last word of a line
0000211c 0000000c 0000
// stall patterns while fetching
00003004 00000018 5a5a
00001040 00000010 00ff
00004ff0 00000010 3333
000010e0 00000008 8001

//--- sim/tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top;

    localparam logic [31:0] reset_pc    = 32'h0000_1000;
    localparam logic [31:0] rom_pattern = 32'h5a5a_0000;
    localparam int          vec_depth   = 64;

    logic        M_AXI_ACLK;
    logic        M_AXI_ARESETN;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        stall;
    logic [31:0] instr;
    logic [31:0] instr_pc;
    logic        instr_valid;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic [1:0]  arburst;
    logic [3:0]  arid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        rlast;
    logic [3:0]  rid;

    logic [31:0] vec_mem [vec_depth];
    logic [31:0] exp_pc;
    int          collected;
    int          ar_since;
    int          cycle_count;
    int          cycle_limit;
    logic        stall_hold;
    // which tag each of the 16 lines should hold
    logic        ref_valid [16];
    logic [22:0] ref_tag [16];

    fetch_top #(
        .reset_pc (reset_pc)
    ) dut_i (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .stall         (stall),
        .instr         (instr),
        .instr_pc      (instr_pc),
        .instr_valid   (instr_valid),
        .araddr        (araddr),
        .arvalid       (arvalid),
        .arready       (arready),
        .arlen         (arlen),
        .arsize        (arsize),
        .arburst       (arburst),
        .arid          (arid),
        .rdata         (rdata),
        .rresp         (rresp),
        .rvalid        (rvalid),
        .rready        (rready),
        .rlast         (rlast),
        .rid           (rid)
    );

    axi_rom_model rom_i (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .araddr        (araddr),
        .arvalid       (arvalid),
        .arready       (arready),
        .arlen         (arlen),
        .arsize        (arsize),
        .arburst       (arburst),
        .arid          (arid),
        .rdata         (rdata),
        .rresp         (rresp),
        .rvalid        (rvalid),
        .rready        (rready),
        .rlast         (rlast),
        .rid           (rid)
    );

    initial M_AXI_ACLK = 1'b0;
    always #50 M_AXI_ACLK = ~M_AXI_ACLK;

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    always @(posedge M_AXI_ACLK)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit)
        begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("Test failed");
            $fatal(1);
        end
    end

    // ------------------------------
    // monitor, sampled mid-cycle
    // ------------------------------
    always @(negedge M_AXI_ACLK)
    begin
        logic [3:0]  line_idx;
        logic [22:0] line_tag;
        logic        ref_hit;
        if (M_AXI_ARESETN)
        begin
            if (arvalid && arready)
            begin
                check_equal("araddr[4:0]", 32'(araddr[4:0]), 32'd0);
                check_equal("araddr", araddr, exp_pc & ~32'h1f);
                check_equal("arlen", 32'(arlen), 32'd7);
                check_equal("arsize", 32'(arsize), 32'd2);
                check_equal("arburst", 32'(arburst), 32'd1);
                check_equal("arid", 32'(arid), 32'd0);
                ar_since = ar_since + 1;
            end
            if (instr_valid)
            begin
                check_equal("instr_valid while stalled", 32'(stall_hold), 32'd0);
                check_equal("instr_pc", instr_pc, exp_pc);
                check_equal("instr", instr, exp_pc ^ rom_pattern);
                // 32 byte lines, 16 of them
                line_idx = exp_pc[8:5];
                line_tag = exp_pc[31:9];
                ref_hit  = ref_valid[line_idx] && (ref_tag[line_idx] == line_tag);
                check_equal("ar handshakes before instr", 32'(ar_since),
                            ref_hit ? 32'd0 : 32'd1);
                ref_valid[line_idx] = 1'b1;
                ref_tag[line_idx]   = line_tag;
                ar_since  = 0;
                exp_pc    = exp_pc + 32'd4;
                collected = collected + 1;
            end
        end
    end

    task automatic apply_reset();
        repeat (15) @(posedge M_AXI_ACLK);
        @(negedge M_AXI_ACLK);
        check_equal("arvalid in reset", 32'(arvalid), 32'd0);
        check_equal("rready in reset", 32'(rready), 32'd0);
        check_equal("instr_valid in reset", 32'(instr_valid), 32'd0);
        @(posedge M_AXI_ACLK);
        #1;
        M_AXI_ARESETN = 1'b1;
        // req cannot be up yet in the release cycle
        @(negedge M_AXI_ACLK);
        check_equal("arvalid after reset", 32'(arvalid), 32'd0);
        check_equal("rready after reset", 32'(rready), 32'd0);
        check_equal("instr_valid after reset", 32'(instr_valid), 32'd0);
    endtask

    // stall until two quiet cycles show nothing outstanding
    task automatic drain_fetch();
        int quiet_run;
        int start_count;
        quiet_run   = 0;
        start_count = collected;
        stall       = 1'b1;
        while (quiet_run < 2)
        begin
            @(negedge M_AXI_ACLK);
            if (!instr_valid && !arvalid && !rready)
            begin
                quiet_run = quiet_run + 1;
            end
            else
            begin
                quiet_run = 0;
            end
        end
        // only the request already raised may still complete
        if (collected - start_count > 1)
        begin
            check_equal("instrs after stall", 32'(collected - start_count), 32'd1);
        end
        stall_hold = 1'b1;
    endtask

    task automatic send_redirect(input logic [31:0] target);
        @(posedge M_AXI_ACLK);
        #1;
        redirect    = 1'b1;
        redirect_pc = target;
        exp_pc      = target;
        @(posedge M_AXI_ACLK);
        #1;
        redirect = 1'b0;
    endtask

    task automatic run_vector(input int v);
        logic [31:0] target;
        logic [15:0] mask;
        int          goal;
        int          phase;
        target = vec_mem[1 + 3 * v];
        goal   = collected + int'(vec_mem[2 + 3 * v]);
        mask   = vec_mem[3 + 3 * v][15:0];
        phase  = 0;
        if (v == 0)
        begin
            check_equal("first vector target", target, reset_pc);
        end
        else
        begin
            drain_fetch();
            send_redirect(target);
        end
        while (collected < goal)
        begin
            @(posedge M_AXI_ACLK);
            #1;
            stall_hold = 1'b0;
            stall      = mask[phase];
            phase      = (phase + 1) % 16;
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial
    begin
        int total;
        M_AXI_ARESETN = 1'b0;
        redirect      = 1'b0;
        redirect_pc   = '0;
        stall         = 1'b0;
        exp_pc        = reset_pc;
        collected     = 0;
        ar_since      = 0;
        cycle_count   = 0;
        cycle_limit   = 0;
        stall_hold    = 1'b0;
        total         = 0;
        for (int i = 0; i < 16; i++)
        begin
            ref_valid[i] = 1'b0;
            ref_tag[i]   = '0;
        end
        foreach (vec_mem[i])
        begin
            vec_mem[i] = '0;
        end
        $readmemh("sim/fetch_vectors.txt", vec_mem);
        if ($isunknown(vec_mem[0]) || vec_mem[0] == 0 || vec_mem[0] > (vec_depth - 1) / 3)
        begin
            $display("vector file is missing or has no usable lines");
            $display("Test failed");
            $fatal(1);
        end
        else
        begin
            for (int v = 0; v < int'(vec_mem[0]); v++)
            begin
                total = total + int'(vec_mem[2 + 3 * v]);
            end
            cycle_limit = total * 40 + 16;
            apply_reset();
            for (int v = 0; v < int'(vec_mem[0]); v++)
            begin
                run_vector(v);
            end
            drain_fetch();
            // every refill must have delivered an instruction
            check_equal("ar handshakes after last instr", 32'(ar_since), 32'd0);
            $display("Test passed");
            $finish;
        end
    end

endmodule

//--- sim/axi_rom_model.sv
`timescale 1ns/1ps

module axi_rom_model
(
    input  logic        M_AXI_ACLK,
    input  logic        M_AXI_ARESETN,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    input  logic [7:0]  arlen,
    input  logic [2:0]  arsize,
    input  logic [1:0]  arburst,
    input  logic [3:0]  arid,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    output logic        rlast,
    output logic [3:0]  rid
);

    localparam logic [31:0] rom_pattern = 32'h5a5a_0000;

    logic [31:0] lcg_state;
    logic [31:0] beat_addr;
    logic [7:0]  burst_len;

    // 0 to 3 wait cycles from the upper lcg bits
    function automatic logic [1:0] next_delay();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[17:16];
    endfunction

    // returns just after a rising edge
    task automatic idle_cycles(input int count);
        repeat (count)
        begin
            @(posedge M_AXI_ACLK);
            #1;
        end
    endtask

    // ------------------------------
    // one burst at a time
    // ------------------------------
    initial
    begin
        int   beat;
        logic accepted;
        lcg_state = 32'h0973_6c10;
        arready   = 1'b0;
        rvalid    = 1'b0;
        rlast     = 1'b0;
        rdata     = '0;
        rresp     = '0;
        rid       = '0;
        idle_cycles(1);
        forever
        begin
            if (M_AXI_ARESETN && arvalid)
            begin
                idle_cycles(next_delay());
                // arvalid is held, so the handshake lands on the next edge
                arready   = 1'b1;
                beat_addr = araddr;
                burst_len = arlen;
                idle_cycles(1);
                arready = 1'b0;
                for (beat = 0; beat <= burst_len; beat++)
                begin
                    idle_cycles(next_delay());
                    rvalid   = 1'b1;
                    rdata    = beat_addr ^ rom_pattern;
                    rlast    = (beat == burst_len);
                    accepted = 1'b0;
                    while (!accepted)
                    begin
                        accepted = rready;
                        idle_cycles(1);
                    end
                    rvalid    = 1'b0;
                    rlast     = 1'b0;
                    beat_addr = beat_addr + 32'd4;
                end
            end
            else
            begin
                idle_cycles(1);
            end
        end
    end

endmodule

//--- design/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
    import icache_pkg::*;
#(
    parameter logic [31:0] reset_pc = 32'h0000_0000
)
(
    input  logic        M_AXI_ACLK,
    input  logic        M_AXI_ARESETN,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    input  logic        stall,
    output logic [31:0] instr,
    output logic [31:0] instr_pc,
    output logic        instr_valid,
    // axi read ports
    output logic [31:0] araddr,
    output logic        arvalid,
    input  logic        arready,
    output logic [7:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,
    output logic [3:0]  arid,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic        rvalid,
    output logic        rready,
    input  logic        rlast,
    input  logic [3:0]  rid
);

    logic        fetch_req;
    fetch_addr_t fetch_addr;
    logic        fetch_valid;
    logic [31:0] fetch_data;

    ifetch #(
        .reset_pc (reset_pc)
    ) ifetch_i (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .stall         (stall),
        .req           (fetch_req),
        .addr          (fetch_addr),
        .valid         (fetch_valid),
        .data          (fetch_data),
        .instr         (instr),
        .instr_pc      (instr_pc),
        .instr_valid   (instr_valid)
    );

    icache icache_i (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .req           (fetch_req),
        .addr          (fetch_addr),
        .valid         (fetch_valid),
        .data          (fetch_data),
        .araddr        (araddr),
        .arvalid       (arvalid),
        .arready       (arready),
        .arlen         (arlen),
        .arsize        (arsize),
        .arburst       (arburst),
        .arid          (arid),
        .rdata         (rdata),
        .rresp         (rresp),
        .rvalid        (rvalid),
        .rready        (rready),
        .rlast         (rlast),
        .rid           (rid)
    );

endmodule

//--- design/ifetch.sv
`timescale 1ns/1ps

module ifetch
    import icache_pkg::*;
#(
    parameter logic [31:0] reset_pc = 32'h0000_0000
)
(
    input  logic        M_AXI_ACLK,
    input  logic        M_AXI_ARESETN,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    input  logic        stall,
    output logic        req,
    output fetch_addr_t addr,
    input  logic        valid,
    input  logic [31:0] data,
    output logic [31:0] instr,
    output logic [31:0] instr_pc,
    output logic        instr_valid
);

    logic [31:0] pc;
    logic        req_q;
    logic        redir_pend;
    logic [31:0] redir_target;
    logic        miss_wait;

    // request raised but not answered this cycle
    assign miss_wait = req_q && !valid;

    // ------------------------------
    // request level
    // ------------------------------
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            req_q <= 1'b0;
        end
        else if (miss_wait)
        begin
            req_q <= 1'b1;
        end
        else
        begin
            req_q <= !stall;
        end
    end

    // ------------------------------
    // pc and redirect
    // ------------------------------
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            pc         <= reset_pc;
            redir_pend <= 1'b0;
        end
        else if (redirect && !miss_wait)
        begin
            pc         <= redirect_pc;
            redir_pend <= 1'b0;
        end
        else if (req_q && valid)
        begin
            pc         <= redir_pend ? redir_target : pc + 32'd4;
            redir_pend <= 1'b0;
        end
        else if (redirect)
        begin
            // applied once the outstanding word is delivered
            redir_pend <= 1'b1;
        end
    end

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (redirect && miss_wait)
        begin
            redir_target <= redirect_pc;
        end
    end

    assign req         = req_q;
    assign addr        = pc;
    assign instr       = data;
    assign instr_pc    = pc;
    assign instr_valid = req_q && valid;

endmodule

//--- design/icache.sv
`timescale 1ns/1ps

module icache
    import icache_pkg::*;
(
    input  logic        M_AXI_ACLK,
    input  logic        M_AXI_ARESETN,
    input  logic        req,
    input  fetch_addr_t addr,
    output logic        valid,
    output logic [31:0] data,
    // axi read ports
    output logic [31:0] araddr,
    output logic        arvalid,
    input  logic        arready,
    output logic [7:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,
    output logic [3:0]  arid,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic        rvalid,
    output logic        rready,
    input  logic        rlast,
    input  logic [3:0]  rid
);

    localparam logic [31:0] line_mask = 32'(line_words * 4 - 1);

    logic                   hit;
    logic [31:0]            hit_data;
    logic                   miss_start;
    logic [31:0]            line_addr;
    logic                   beat_en;
    logic [offset_bits-1:0] beat_count;
    logic [31:0]            beat_data;
    logic                   last_beat;
    logic                   refill_idle;
    logic                   want_last_word;

    icache_array array_i (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .lookup_addr   (addr),
        .hit           (hit),
        .hit_data      (hit_data),
        .fill_en       (beat_en),
        .fill_index    (addr.fields.index),
        .fill_word     (beat_count),
        .fill_data     (beat_data),
        .fill_done     (last_beat)
    );

    // ------------------------------
    // miss handling
    // ------------------------------
    assign refill_idle = !arvalid && !rready;
    assign miss_start  = req && !hit && refill_idle;
    assign line_addr   = addr.flat & ~line_mask;

    icache_refill refill_i (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .start         (miss_start),
        .line_addr     (line_addr),
        .araddr        (araddr),
        .arvalid       (arvalid),
        .arready       (arready),
        .arlen         (arlen),
        .arsize        (arsize),
        .arburst       (arburst),
        .arid          (arid),
        .rdata         (rdata),
        .rresp         (rresp),
        .rvalid        (rvalid),
        .rready        (rready),
        .rlast         (rlast),
        .rid           (rid),
        .beat_en       (beat_en),
        .beat_count    (beat_count),
        .beat_data     (beat_data),
        .last_beat     (last_beat)
    );

    // the last word is still on the bus, earlier ones already sit in the array
    assign want_last_word = addr.fields.offset == offset_bits'(line_words - 1);

    assign valid = (req && hit) || last_beat;
    assign data  = (last_beat && want_last_word) ? beat_data : hit_data;

endmodule

//--- design/icache_refill.sv
`timescale 1ns/1ps

module icache_refill
    import icache_pkg::*;
(
    input  logic                   M_AXI_ACLK,
    input  logic                   M_AXI_ARESETN,
    input  logic                   start,
    input  logic [31:0]            line_addr,
    // read address channel
    output logic [31:0]            araddr,
    output logic                   arvalid,
    input  logic                   arready,
    output logic [7:0]             arlen,
    output logic [2:0]             arsize,
    output logic [1:0]             arburst,
    output logic [3:0]             arid,
    // read data channel
    input  logic [31:0]            rdata,
    input  logic [1:0]             rresp,
    input  logic                   rvalid,
    output logic                   rready,
    input  logic                   rlast,
    input  logic [3:0]             rid,
    // beat stream towards the array
    output logic                   beat_en,
    output logic [offset_bits-1:0] beat_count,
    output logic [31:0]            beat_data,
    output logic                   last_beat
);

    logic                   arvalid_q;
    logic                   rready_q;
    logic [31:0]            araddr_q;
    logic [offset_bits-1:0] beat_q;
    logic                   idle;

    assign idle = !arvalid_q && !rready_q;

    // ------------------------------
    // address phase
    // ------------------------------
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            arvalid_q <= 1'b0;
        end
        else if (start && idle)
        begin
            arvalid_q <= 1'b1;
        end
        else if (arready)
        begin
            arvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (start && idle)
        begin
            araddr_q <= line_addr;
        end
    end

    // ------------------------------
    // data phase
    // ------------------------------
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            rready_q <= 1'b0;
        end
        else if (arvalid_q && arready)
        begin
            rready_q <= 1'b1;
        end
        else if (last_beat)
        begin
            rready_q <= 1'b0;
        end
    end

    // word number of the next beat in the line
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (arvalid_q && arready)
        begin
            beat_q <= '0;
        end
        else if (beat_en)
        begin
            beat_q <= beat_q + 1'b1;
        end
    end

    assign araddr  = araddr_q;
    assign arvalid = arvalid_q;
    assign arlen   = axi_len_line;
    assign arsize  = axi_size_word;
    assign arburst = axi_burst_incr;
    assign arid    = '0;
    assign rready  = rready_q;

    assign beat_en    = rvalid && rready_q;
    assign beat_count = beat_q;
    assign beat_data  = rdata;
    assign last_beat  = beat_en && rlast;

endmodule

//--- design/icache_array.sv
`timescale 1ns/1ps

module icache_array
    import icache_pkg::*;
(
    input  logic                   M_AXI_ACLK,
    input  logic                   M_AXI_ARESETN,
    input  fetch_addr_t            lookup_addr,
    output logic                   hit,
    output logic [31:0]            hit_data,
    input  logic                   fill_en,
    input  logic [index_bits-1:0]  fill_index,
    input  logic [offset_bits-1:0] fill_word,
    input  logic [31:0]            fill_data,
    input  logic                   fill_done
);

    localparam int word_addr_bits = index_bits + offset_bits;

    logic [line_count-1:0]     line_valid;
    logic [tag_bits-1:0]       line_tag [line_count];
    logic [31:0]               data_mem [line_count*line_words];
    logic [word_addr_bits-1:0] fill_addr;
    logic [word_addr_bits-1:0] read_addr;
    logic [index_bits-1:0]     lookup_index;

    assign lookup_index = lookup_addr.fields.index;
    assign fill_addr    = {fill_index, fill_word};
    assign read_addr    = {lookup_index, lookup_addr.fields.offset};

    // ------------------------------
    // line state
    // ------------------------------
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            line_valid <= '0;
        end
        else if (fill_done)
        begin
            line_valid[fill_index] <= 1'b1;
        end
    end

    // the missing address is held through the refill, so its tag
    // is still on the lookup side when the last beat lands
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (fill_done)
        begin
            line_tag[fill_index] <= lookup_addr.fields.tag;
        end
    end

    // ------------------------------
    // data words
    // ------------------------------
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (fill_en)
        begin
            data_mem[fill_addr] <= fill_data;
        end
    end

    // lookup is purely combinational so hits return in the request cycle
    assign hit      = line_valid[lookup_index]
                      && (line_tag[lookup_index] == lookup_addr.fields.tag);
    assign hit_data = data_mem[read_addr];

endmodule

//--- design/icache_pkg.sv
package icache_pkg;

    // ------------------------------
    // cache geometry
    // ------------------------------
    localparam int line_words  = 8;
    localparam int line_count  = 16;
    localparam int offset_bits = $clog2(line_words);
    localparam int index_bits  = $clog2(line_count);
    // 2 byte bits below the word offset
    localparam int tag_bits    = 32 - index_bits - offset_bits - 2;

    // ------------------------------
    // axi read burst codes
    // ------------------------------
    // one burst covers a whole line
    localparam logic [7:0] axi_len_line   = 8'(line_words - 1);
    localparam logic [2:0] axi_size_word  = 3'b010;
    localparam logic [1:0] axi_burst_incr = 2'b01;

    // fetch address split for lookup
    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [index_bits-1:0]  index;
        logic [offset_bits-1:0] offset;
        logic [1:0]             byte_sel;
    } fetch_fields_t;

    // same word, seen flat for the bus or split for the arrays
    typedef union packed {
        logic [31:0]   flat;
        fetch_fields_t fields;
    } fetch_addr_t;

endpackage
